// File: filelist.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/hci.sv
rtl/ram.sv
rtl/soc_top.sv
verif/tb_soc.sv

// File: Bender.yml
package:
  name: soc_hostdebug

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_pkg.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/hci.sv
      - rtl/ram.sv
      - rtl/soc_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/tb_soc.sv

// File: verif/tb_soc.sv
// ----------------------------------------
// soc testbench: host on the uart and the
// processor on the byte bus, table driven
// ----------------------------------------
`timescale 1ns/1ns
`include "soc_macros.svh"

module tb_soc;

	localparam int max_rows = 32;
	localparam int max_bytes = 24;
	localparam int k_host = 0;
	localparam int k_cpu_wr = 1;
	localparam int k_cpu_rd = 2;
	localparam int k_io_wr = 3;
	localparam int k_console = 4;
	localparam int k_io_rd = 5;
	localparam logic [31:0] io_base = 32'h0001_8000;

	logic clk;
	logic btnC;
	logic Rx;
	logic Tx;
	logic led;
	soc_pkg::cpu_addr_t cpu_mem_a;
	logic cpu_mem_wr;
	soc_pkg::byte_t cpu_mem_dout;
	soc_pkg::byte_t cpu_mem_din;
	logic cpu_rdy;

	// stimulus table, one entry per row
	string row_name [max_rows];
	int row_kind [max_rows];
	logic [31:0] row_addr [max_rows];
	soc_pkg::byte_t row_out [max_rows][max_bytes];
	int row_out_n [max_rows];
	soc_pkg::byte_t row_exp [max_rows][max_bytes];
	int row_exp_n [max_rows];
	logic row_active [max_rows];
	int n_rows = 0;
	logic table_ready = 1'b0;

	// reference model of RAM, break flag and console byte
	soc_pkg::byte_t ref_mem [0:(1 << `SOC_RAM_ADDR_WIDTH) - 1];
	logic ref_active;
	soc_pkg::byte_t ref_console;
	soc_pkg::byte_t cmd_q [$];
	soc_pkg::byte_t exp_q [$];

	soc_pkg::byte_t rx_buf [max_bytes];
	int errors = 0;

	soc_top soc_top_i (.clk(clk), .btnC(btnC), .Rx(Rx), .Tx(Tx), .led(led),
		.cpu_mem_a(cpu_mem_a), .cpu_mem_wr(cpu_mem_wr), .cpu_mem_dout(cpu_mem_dout),
		.cpu_mem_din(cpu_mem_din), .cpu_rdy(cpu_rdy));

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	task automatic push_row(input string name, input int kind, input logic [31:0] addr);
		row_name[n_rows] = name;
		row_kind[n_rows] = kind;
		row_addr[n_rows] = addr;
		row_active[n_rows] = ref_active;
		row_out_n[n_rows] = cmd_q.size();
		row_exp_n[n_rows] = exp_q.size();
		foreach (cmd_q[i])
			row_out[n_rows][i] = cmd_q[i];
		foreach (exp_q[i])
			row_exp[n_rows][i] = exp_q[i];
		cmd_q.delete();
		exp_q.delete();
		n_rows++;
	endtask

	// echo, break and run
	task automatic add_host(input string name, input soc_pkg::byte_t op,
		input soc_pkg::byte_t arg);
		cmd_q.push_back(op);
		if (op == `SOC_OP_ECHO)
		begin
			cmd_q.push_back(arg);
			exp_q.push_back(arg);
		end
		if (op == `SOC_OP_BREAK)
			ref_active = 1'b1;
		if (op == `SOC_OP_RUN)
			ref_active = 1'b0;
		push_row(name, k_host, 32'd0);
	endtask

	// block read or write, honoured only in a break
	task automatic add_block(input string name, input soc_pkg::byte_t op,
		input logic [31:0] a, input int n);
		cmd_q = {op, a[7:0], a[15:8], a[23:16], 8'(n), 8'(n >> 8)};
		for (int i = 0; i < n; i++)
		begin
			if (op == `SOC_OP_WRITE)
			begin
				cmd_q.push_back(soc_pkg::byte_t'($urandom));
				if (ref_active)
					ref_mem[17'(a + i)] = cmd_q[6 + i];
			end
			else if (ref_active)
				exp_q.push_back(ref_mem[17'(a + i)]);
		end
		push_row(name, k_host, a);
	endtask

	task automatic add_cpu(input string name, input int kind, input logic [31:0] a,
		input soc_pkg::byte_t d);
		cmd_q.push_back(d);
		case (kind)
			k_cpu_wr: ref_mem[a[16:0]] = d;
			k_cpu_rd: exp_q.push_back(ref_mem[a[16:0]]);
			k_io_wr: exp_q.push_back(d);
			k_console: ref_console = d;
			default: exp_q.push_back(ref_console);
		endcase
		push_row(name, kind, a);
	endtask

	task automatic build_table();
		logic [31:0] blk_a;
		logic [31:0] cpu_a;
		// keep both blocks below the io window
		blk_a = $urandom % 32'h1_7f00;
		cpu_a = ($urandom % 32'h7ff0) & ~32'h7;
		add_host("echo a5", `SOC_OP_ECHO, 8'ha5);
		add_host("echo random", `SOC_OP_ECHO, soc_pkg::byte_t'($urandom));
		add_host("break", `SOC_OP_BREAK, 8'h00);
		add_block("host write block", `SOC_OP_WRITE, blk_a, 8);
		add_block("host read block", `SOC_OP_READ, blk_a, 8);
		add_block("host read inside block", `SOC_OP_READ, blk_a + 3, 2);
		add_host("run", `SOC_OP_RUN, 8'h00);
		add_block("host write outside break", `SOC_OP_WRITE, blk_a, 4);
		add_cpu("cpu write 0", k_cpu_wr, cpu_a, soc_pkg::byte_t'($urandom));
		add_cpu("cpu write 1", k_cpu_wr, cpu_a + 1, soc_pkg::byte_t'($urandom));
		add_cpu("cpu read 0", k_cpu_rd, cpu_a, 8'h00);
		add_cpu("cpu read 1", k_cpu_rd, cpu_a + 1, 8'h00);
		add_cpu("console out", k_io_wr, io_base | cpu_a, soc_pkg::byte_t'($urandom));
		add_cpu("ram after console out", k_cpu_rd, cpu_a, 8'h00);
		// top bit set, so never an opcode
		add_cpu("console in", k_console, 32'd0, 8'h80 | soc_pkg::byte_t'($urandom));
		add_cpu("console read", k_io_rd, io_base, 8'h00);
		add_host("break again", `SOC_OP_BREAK, 8'h00);
		add_block("host read cpu bytes", `SOC_OP_READ, cpu_a, 2);
		add_block("host read after ignored write", `SOC_OP_READ, blk_a, 4);
		add_host("run again", `SOC_OP_RUN, 8'h00);
	endtask

	task automatic check_byte(input string name, input soc_pkg::byte_t exp,
		input soc_pkg::byte_t got);
		assert (got === exp)
		else
		begin
			errors++;
			$display("[FAIL] %s: expected %02h, actual %02h", name, exp, got);
		end
	endtask

	task automatic send_byte(input soc_pkg::byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			Rx = frame[i];
			repeat (`SOC_CLKS_PER_BIT) @(posedge clk);
			#2;
		end
	endtask

	// sample Tx at bit middles on falling edges
	task automatic recv_bytes(input int n);
		for (int k = 0; k < n; k++)
		begin
			while (Tx !== 1'b0)
				@(negedge clk);
			repeat (`SOC_CLKS_PER_BIT / 2) @(negedge clk);
			for (int i = 0; i < 8; i++)
			begin
				repeat (`SOC_CLKS_PER_BIT) @(negedge clk);
				rx_buf[k][i] = Tx;
			end
			repeat (`SOC_CLKS_PER_BIT) @(negedge clk);
			assert (Tx === 1'b1)
			else
			begin
				errors++;
				$display("framing error: Tx stop bit was not high in reply byte %0d", k);
			end
		end
	endtask

	task automatic cpu_access(input logic [31:0] a, input logic wr, input soc_pkg::byte_t d,
		output soc_pkg::byte_t q);
		assert (cpu_rdy === 1'b1)
		else
		begin
			errors++;
			$display("processor bus was not ready for an access at %08h", a);
		end
		cpu_mem_a = a;
		cpu_mem_wr = wr;
		cpu_mem_dout = d;
		@(posedge clk);
		#2;
		q = cpu_mem_din;
		cpu_mem_a = '0;
		cpu_mem_wr = 1'b0;
	endtask

	task automatic apply_row(input int r);
		soc_pkg::byte_t q;
		soc_pkg::byte_t got;
		case (row_kind[r])
			k_host, k_console:
			begin
				fork
					for (int i = 0; i < row_out_n[r]; i++)
						send_byte(row_out[r][i]);
					recv_bytes(row_exp_n[r]);
				join
			end
			k_io_wr:
			begin
				fork
					cpu_access(row_addr[r], 1'b1, row_out[r][0], q);
					recv_bytes(1);
				join
			end
			default:
				cpu_access(row_addr[r], row_kind[r] == k_cpu_wr, row_out[r][0], q);
		endcase
		// let the last frame on Tx run out
		repeat (`SOC_CLKS_PER_BIT) @(posedge clk);
		#2;
		for (int i = 0; i < row_exp_n[r]; i++)
		begin
			got = (row_kind[r] == k_cpu_rd || row_kind[r] == k_io_rd) ? q : rx_buf[i];
			check_byte(row_name[r], row_exp[r][i], got);
		end
		if (row_kind[r] == k_host)
			check_byte({row_name[r], " led/cpu_rdy"}, {6'd0, row_active[r], !row_active[r]},
				{6'd0, led, cpu_rdy});
	endtask

	initial
	begin
		btnC = 1'b1;
		Rx = 1'b1;
		cpu_mem_a = '0;
		cpu_mem_wr = 1'b0;
		cpu_mem_dout = '0;
		ref_active = 1'b0;
		ref_console = '0;
		void'($urandom(32'h3c51));
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		btnC = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		for (int r = 0; r < n_rows; r++)
			apply_row(r);
		$display("rows: %0d, errors: %0d", n_rows, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// twelve frames per row on average, plus reset and slack
	initial
	begin
		wait (table_ready);
		#(n_rows * 12 * 10 * `SOC_CLKS_PER_BIT * 20 + 200000);
		$display("timeout: the DUT stopped answering before all rows were applied");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: rtl/soc_top.sv
// ----------------------------------------
// soc top: reset sync, bus mux, io decode
// ----------------------------------------
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_top
(
	input  logic               clk,
	input  logic               btnC,
	input  logic               Rx,
	output logic               Tx,
	output logic               led,
	input  soc_pkg::cpu_addr_t cpu_mem_a,
	input  logic               cpu_mem_wr,
	input  soc_pkg::byte_t     cpu_mem_dout,
	output soc_pkg::byte_t     cpu_mem_din,
	output logic               cpu_rdy
);

	logic rst;
	logic rst_meta;
	soc_pkg::cpu_addr_t mem_a;
	logic mem_wr;
	soc_pkg::byte_t mem_dout;
	logic io_en;
	logic io_en_q;
	soc_pkg::byte_t ram_dout;
	soc_pkg::byte_t rx_data;
	logic rx_valid;
	soc_pkg::byte_t tx_data;
	logic tx_start;
	logic tx_busy;
	logic hci_active;
	soc_pkg::ram_addr_t hci_ram_a;
	logic hci_ram_wr;
	soc_pkg::byte_t hci_ram_dout;
	soc_pkg::byte_t hci_io_dout;

	// release two edges after btnC falls
	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			rst_meta <= 1'b1;
			rst      <= 1'b1;
		end
		else
		begin
			rst_meta <= 1'b0;
			rst      <= rst_meta;
		end
	end

	// hci owns the bus during a debug break
	assign mem_a    = hci_active ? soc_pkg::cpu_addr_t'(hci_ram_a) : cpu_mem_a;
	assign mem_wr   = hci_active ? hci_ram_wr : cpu_mem_wr;
	assign mem_dout = hci_active ? hci_ram_dout : cpu_mem_dout;
	assign cpu_rdy  = !hci_active;
	assign led      = hci_active;

	// top quarter of the address space is io
	assign io_en = mem_a[`SOC_RAM_ADDR_WIDTH-1] & mem_a[`SOC_RAM_ADDR_WIDTH-2];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			io_en_q <= 1'b0;
		else
			io_en_q <= io_en;
	end

	assign cpu_mem_din = io_en_q ? hci_io_dout : ram_dout;

	uart_rx uart_rx_i (.clk(clk), .rst(rst), .rx(Rx), .rx_data(rx_data), .rx_valid(rx_valid));

	uart_tx uart_tx_i (.clk(clk), .rst(rst), .tx_data(tx_data), .tx_start(tx_start),
		.tx(Tx), .tx_busy(tx_busy));

	hci hci_i (.clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
		.tx_data(tx_data), .tx_start(tx_start), .tx_busy(tx_busy), .active(hci_active),
		.ram_a(hci_ram_a), .ram_wr(hci_ram_wr), .ram_dout(hci_ram_dout), .ram_din(ram_dout),
		.io_en(io_en), .io_sel(mem_a[2:0]), .io_wr(mem_wr), .io_din(mem_dout),
		.io_dout(hci_io_dout));

	ram ram_i (.clk(clk), .en(!io_en), .wr(mem_wr), .a(mem_a[`SOC_RAM_ADDR_WIDTH-1:0]),
		.d_in(mem_dout), .d_out(ram_dout));

endmodule

// File: rtl/ram.sv
// ----------------------------------------
// single-port byte RAM, registered read
// ----------------------------------------
`timescale 1ns/1ns
`include "soc_macros.svh"

module ram
(
	input  logic               clk,
	input  logic               en,
	input  logic               wr,
	input  soc_pkg::ram_addr_t a,
	input  soc_pkg::byte_t     d_in,
	output soc_pkg::byte_t     d_out
);

	soc_pkg::byte_t mem [0:(1 << `SOC_RAM_ADDR_WIDTH) - 1];

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (wr)
				mem[a] <= d_in;
			// old data on a write cycle
			d_out <= mem[a];
		end
	end

endmodule

// File: rtl/hci.sv
// ----------------------------------------
// host command engine, debug break owner
// and console byte router
// ----------------------------------------
`timescale 1ns/1ns
`include "soc_macros.svh"

module hci
(
	input  logic               clk,
	input  logic               rst,
	input  soc_pkg::byte_t     rx_data,
	input  logic               rx_valid,
	output soc_pkg::byte_t     tx_data,
	output logic               tx_start,
	input  logic               tx_busy,
	output logic               active,
	output soc_pkg::ram_addr_t ram_a,
	output logic               ram_wr,
	output soc_pkg::byte_t     ram_dout,
	input  soc_pkg::byte_t     ram_din,
	input  logic               io_en,
	input  soc_pkg::io_sel_t   io_sel,
	input  logic               io_wr,
	input  soc_pkg::byte_t     io_din,
	output soc_pkg::byte_t     io_dout
);

	soc_pkg::hci_state_t state;
	soc_pkg::byte_t op;
	soc_pkg::len_t len;
	soc_pkg::byte_t console;
	logic echo_full;
	logic is_op;
	logic console_go;

	assign is_op = (rx_data <= `SOC_OP_RUN);

	// processor console write, engine replies take the transmitter first
	assign console_go = !active && io_en && io_wr && (io_sel == 3'd0) &&
		!tx_busy && !tx_start && (state != soc_pkg::echo_send);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= soc_pkg::idle;
			active    <= 1'b0;
			op        <= '0;
			len       <= '0;
			ram_a     <= '0;
			ram_wr    <= 1'b0;
			ram_dout  <= '0;
			tx_data   <= '0;
			tx_start  <= 1'b0;
			console   <= '0;
			echo_full <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0;
			ram_wr   <= 1'b0;
			// step past each written byte
			if (ram_wr)
				ram_a <= ram_a + 1'b1;
			if (console_go)
			begin
				tx_data  <= io_din;
				tx_start <= 1'b1;
			end

			case (state)
				soc_pkg::idle:
				begin
					if (rx_valid && is_op)
					begin
						op    <= rx_data;
						state <= soc_pkg::decode;
					end
					else if (rx_valid && !active)
						console <= rx_data;
				end
				soc_pkg::decode:
				begin
					case (op)
						`SOC_OP_ECHO:  state <= soc_pkg::echo_send;
						`SOC_OP_READ:  state <= soc_pkg::addr0;
						`SOC_OP_WRITE: state <= soc_pkg::addr0;
						`SOC_OP_BREAK:
						begin
							active <= 1'b1;
							state  <= soc_pkg::idle;
						end
						default:
						begin
							active <= 1'b0;
							state  <= soc_pkg::idle;
						end
					endcase
				end
				soc_pkg::addr0:
				begin
					if (rx_valid)
					begin
						ram_a[7:0] <= rx_data;
						state      <= soc_pkg::addr1;
					end
				end
				soc_pkg::addr1:
				begin
					if (rx_valid)
					begin
						ram_a[15:8] <= rx_data;
						state       <= soc_pkg::addr2;
					end
				end
				soc_pkg::addr2:
				begin
					// upper address bits beyond the RAM are dropped
					if (rx_valid)
					begin
						ram_a[`SOC_RAM_ADDR_WIDTH-1:16] <=
							rx_data[`SOC_RAM_ADDR_WIDTH-17:0];
						state <= soc_pkg::len0;
					end
				end
				soc_pkg::len0:
				begin
					if (rx_valid)
					begin
						len[7:0] <= rx_data;
						state    <= soc_pkg::len1;
					end
				end
				soc_pkg::len1:
				begin
					if (rx_valid)
					begin
						len[15:8] <= rx_data;
						if ({rx_data, len[7:0]} == 16'd0)
							state <= soc_pkg::idle;
						else if (op == `SOC_OP_WRITE)
							state <= soc_pkg::write_data;
						else if (active)
							state <= soc_pkg::read_issue;
						else
							state <= soc_pkg::idle;
					end
				end
				soc_pkg::read_issue: state <= soc_pkg::read_wait;
				soc_pkg::read_wait:  state <= soc_pkg::read_send;
				soc_pkg::read_send:
				begin
					if (!tx_busy && !tx_start)
					begin
						tx_data  <= ram_din;
						tx_start <= 1'b1;
						ram_a    <= ram_a + 1'b1;
						len      <= len - 16'd1;
						state    <= (len == 16'd1) ? soc_pkg::idle : soc_pkg::read_issue;
					end
				end
				soc_pkg::write_data:
				begin
					if (rx_valid)
					begin
						ram_wr   <= active;
						ram_dout <= rx_data;
						len      <= len - 16'd1;
						if (len == 16'd1)
							state <= soc_pkg::idle;
					end
				end
				default:
				begin
					// echo_send: take one byte, return it when the line is free
					if (rx_valid)
					begin
						tx_data   <= rx_data;
						echo_full <= 1'b1;
					end
					else if (echo_full && !tx_busy && !tx_start)
					begin
						tx_start  <= 1'b1;
						echo_full <= 1'b0;
						state     <= soc_pkg::idle;
					end
				end
			endcase
		end
	end

	// io read data follows the RAM read latency
	always_ff @(posedge clk)
	begin
		if (io_en && !io_wr)
			io_dout <= (io_sel == 3'd0) ? console : 8'h00;
	end

endmodule

// File: rtl/uart_tx.sv
// ----------------------------------------
// uart transmitter, 8n1, lsb first
// ----------------------------------------
`timescale 1ns/1ns
`include "soc_macros.svh"

module uart_tx
(
	input  logic           clk,
	input  logic           rst,
	input  soc_pkg::byte_t tx_data,
	input  logic           tx_start,
	output logic           tx,
	output logic           tx_busy
);

	localparam int cnt_w = $clog2(`SOC_CLKS_PER_BIT);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`SOC_CLKS_PER_BIT - 1);

	// stop, data, start
	logic [9:0] shreg;
	logic [3:0] bit_cnt;
	logic [cnt_w-1:0] clk_cnt;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			shreg   <= '1;
			bit_cnt <= '0;
			clk_cnt <= '0;
			tx_busy <= 1'b0;
		end
		else if (!tx_busy)
		begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			if (tx_start)
			begin
				shreg   <= {1'b1, tx_data, 1'b0};
				tx_busy <= 1'b1;
			end
		end
		else if (clk_cnt == cnt_last)
		begin
			clk_cnt <= '0;
			bit_cnt <= bit_cnt + 1'b1;
			shreg   <= {1'b1, shreg[9:1]};
			// stop bit done
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;
		end
		else
		begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// line idles high
	assign tx = tx_busy ? shreg[0] : 1'b1;

endmodule

// File: rtl/uart_rx.sv
// ----------------------------------------
// uart receiver, one strobe per byte
// ----------------------------------------
`timescale 1ns/1ns
`include "soc_macros.svh"

module uart_rx
(
	input  logic          clk,
	input  logic          rst,
	input  logic          rx,
	output soc_pkg::byte_t rx_data,
	output logic          rx_valid
);

	localparam int cnt_w = $clog2(`SOC_CLKS_PER_BIT);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`SOC_CLKS_PER_BIT - 1);
	localparam logic [cnt_w-1:0] cnt_half = cnt_w'(`SOC_CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_s;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	soc_pkg::byte_t shreg;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rx_meta  <= 1'b1;
			rx_s     <= 1'b1;
			state    <= rx_idle;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			shreg    <= '0;
			rx_data  <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_meta  <= rx;
			rx_s     <= rx_meta;
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				rx_idle:
				begin
					clk_cnt <= '0;
					if (!rx_s)
						state <= rx_start;
				end
				rx_start:
				begin
					// middle of start bit, a glitch drops the frame
					if (clk_cnt == cnt_half)
					begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_s ? rx_idle : rx_bits;
					end
				end
				rx_bits:
				begin
					if (clk_cnt == cnt_last)
					begin
						clk_cnt <= '0;
						shreg   <= {rx_s, shreg[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= rx_stop;
					end
				end
				default:
				begin
					if (clk_cnt == cnt_last)
					begin
						rx_data  <= shreg;
						rx_valid <= 1'b1;
						state    <= rx_idle;
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/soc_pkg.sv
// ----------------------------------------
// soc shared types and hci state encoding
// ----------------------------------------
`include "soc_macros.svh"

package soc_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] cpu_addr_t;
	typedef logic [`SOC_RAM_ADDR_WIDTH-1:0] ram_addr_t;
	typedef logic [15:0] len_t;
	typedef logic [2:0] io_sel_t;

	// host command engine states
	typedef enum logic [3:0] {
		idle, decode,
		addr0, addr1, addr2,
		len0, len1,
		read_issue, read_wait, read_send,
		write_data, echo_send
	} hci_state_t;

endpackage

// File: rtl/soc_macros.svh
// ----------------------------------------
// soc global constants: RAM size, UART bit
// timing and the host command opcodes
// ----------------------------------------
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// 128 KiB byte RAM
`define SOC_RAM_ADDR_WIDTH 17

// clock cycles per UART bit
`define SOC_CLKS_PER_BIT 16

// host command opcodes
`define SOC_OP_ECHO  8'h00
`define SOC_OP_READ  8'h01
`define SOC_OP_WRITE 8'h02
`define SOC_OP_BREAK 8'h03
`define SOC_OP_RUN   8'h04

`endif
